// File: hdl/ks10IntrPkg.sv
//////////////////////////////
// KS10 interrupt slice types
// Command opcodes, APR flag and PI level
// types shared by the APR, PI and sequencer
//////////////////////////////

package ks10IntrPkg;

   //////////////////////////////
   // PI level types
   //////////////////////////////

   // Level number, 0 = none, 1 = highest, 7 = lowest
   typedef logic [2:0] piLevelT;

   // One bit per level, index n is level n
   typedef logic [7:1] piMaskT;

   //////////////////////////////
   // Command port
   //////////////////////////////

   // Opcodes, each block decodes its own
   typedef enum logic [2:0] {
      aprNop        = 3'd0,    // Idle
      aprClrFlags   = 3'd1,    // Clear flags under mask
      aprSetEnables = 3'd2,    // Load flag enables
      aprSetLevel   = 3'd3,    // Load APR PI level
      piSetOn       = 3'd4,    // Load PI on and level enables
      piDismiss     = 3'd5     // End highest level in progress
   } aprOpT;

   // Data field layout
   //   flag mask    data[3:0]
   //   PI level     data[2:0]
   //   PI on        data[7], level enables data[6:0]
   typedef struct packed {
      logic        valid;      // Act on next edge
      aprOpT       op;         // Opcode
      logic [9:0]  data;       // Operand
   } aprCmdT;

   //////////////////////////////
   // APR flags and requests
   //////////////////////////////

   typedef struct packed {
      logic pwr;               // Power fail
      logic nxm;               // Nonexistent memory
      logic cons;              // Console interrupt
      logic timer;             // Interval timer
   } aprFlagsT;

   // Raw external pulses, timer is internal
   typedef struct packed {
      logic pwr;
      logic nxm;
      logic cons;
   } aprIrqT;

   // Request offered to the sequencer
   typedef struct packed {
      logic     valid;
      piLevelT  level;
   } piReqT;

endpackage

// File: hdl/aprFlags.sv
//////////////////////////////
// APR flags
// Sticky APR flags with enables, the APR PI
// level and the interval timer prescaler
//////////////////////////////

module aprFlags #(
   parameter int tickCycles = 40                  // Clocks per timer tick
) (
   input  logic                  clk,             // Clock
   input  logic                  rst,             // Synchronous reset
   input  ks10IntrPkg::aprCmdT   cmd,             // Command port
   input  ks10IntrPkg::aprIrqT   aprIrq,          // External APR pulses
   input  logic                  timerEN,         // Timer enable
   output ks10IntrPkg::piReqT    aprReq           // Request to sequencer
);

   // Counter wide enough for tickCycles-1
   localparam int cntWidth = (tickCycles > 1) ? $clog2(tickCycles) : 1;

   logic [cntWidth-1:0]     prescale;             // Timer prescaler
   logic                    timerTick;            // One clock per period
   logic                    cmdClr;               // Decoded aprClrFlags
   logic                    cmdEn;                // Decoded aprSetEnables
   logic                    cmdLvl;               // Decoded aprSetLevel
   ks10IntrPkg::aprFlagsT   flags;                // Flag register
   ks10IntrPkg::aprFlagsT   flagsNext;
   ks10IntrPkg::aprFlagsT   flagSet;              // This cycle's set inputs
   ks10IntrPkg::aprFlagsT   flagClr;              // This cycle's clear mask
   ks10IntrPkg::aprFlagsT   enables;              // Flag enables
   ks10IntrPkg::aprFlagsT   enablesNext;
   ks10IntrPkg::piLevelT    aprLevel;             // APR PI level
   ks10IntrPkg::piLevelT    aprLevelNext;

   //////////////////////////////
   // Command decode
   //////////////////////////////

   assign cmdClr = cmd.valid && (cmd.op == ks10IntrPkg::aprClrFlags);
   assign cmdEn  = cmd.valid && (cmd.op == ks10IntrPkg::aprSetEnables);
   assign cmdLvl = cmd.valid && (cmd.op == ks10IntrPkg::aprSetLevel);

   //////////////////////////////
   // Interval timer
   //////////////////////////////

   // Last count of the period
   assign timerTick = timerEN && (prescale == cntWidth'(tickCycles - 1));

   always_ff @(posedge clk) begin
      if (rst || !timerEN) begin
         prescale <= '0;                          // Restart while disabled
      end else if (timerTick) begin
         prescale <= '0;                          // Wrap
      end else begin
         prescale <= prescale + 1'b1;
      end
   end

   //////////////////////////////
   // Flags, enables, level
   //////////////////////////////

   always_comb begin
      flagSet.pwr   = aprIrq.pwr;
      flagSet.nxm   = aprIrq.nxm;
      flagSet.cons  = aprIrq.cons;
      flagSet.timer = timerTick;

      // Mask in low bits, pwr is bit 3
      flagClr = cmdClr ? ks10IntrPkg::aprFlagsT'(cmd.data[3:0]) : '0;

      // Set wins over a clear in the same cycle
      flagsNext = ks10IntrPkg::aprFlagsT'((flags & ~flagClr) | flagSet);

      enablesNext  = cmdEn ? ks10IntrPkg::aprFlagsT'(cmd.data[3:0]) : enables;
      aprLevelNext = cmdLvl ? cmd.data[2:0] : aprLevel;
   end

   // Request built from next state, so it is
   // registered in the same edge as the flag
   always_ff @(posedge clk) begin
      if (rst) begin
         flags    <= '0;
         enables  <= '0;
         aprLevel <= '0;
         aprReq   <= '0;
      end else begin
         flags        <= flagsNext;
         enables      <= enablesNext;
         aprLevel     <= aprLevelNext;
         aprReq.valid <= (|(flagsNext & enablesNext)) && (aprLevelNext != '0);
         aprReq.level <= aprLevelNext;            // Level 0 never requests
      end
   end

endmodule

// File: hdl/piLevels.sv
//////////////////////////////
// PI levels
// PI system on/off, level enables and the
// synchronized, masked Unibus requests
//////////////////////////////

module piLevels (
   input  logic                  clk,             // Clock
   input  logic                  rst,             // Synchronous reset
   input  ks10IntrPkg::aprCmdT   cmd,             // Command port
   input  ks10IntrPkg::piMaskT   ubaIRQ,          // Unibus requests, async
   output ks10IntrPkg::piMaskT   ubaPending,      // Synced and masked
   output ks10IntrPkg::piMaskT   levelActive      // Levels open for service
);

   logic                    cmdOn;                // Decoded piSetOn
   logic                    piOn;                 // PI system on
   ks10IntrPkg::piMaskT     levelEn;              // Level enables
   ks10IntrPkg::piMaskT     ubaSync1;             // First sync stage
   ks10IntrPkg::piMaskT     ubaSync2;             // Second sync stage

   //////////////////////////////
   // PI on and level enables
   //////////////////////////////

   assign cmdOn = cmd.valid && (cmd.op == ks10IntrPkg::piSetOn);

   always_ff @(posedge clk) begin
      if (rst) begin
         piOn    <= 1'b0;
         levelEn <= '0;
      end else if (cmdOn) begin
         piOn    <= cmd.data[7];                  // PI on bit
         levelEn <= cmd.data[6:0];                // Bit n is level n
      end
   end

   // Nothing is active with PI off
   assign levelActive = piOn ? levelEn : '0;

   //////////////////////////////
   // Unibus request sync
   //////////////////////////////

   // Request lines come from the Unibus
   // adapter clock domain, two stages
   always_ff @(posedge clk) begin
      if (rst) begin
         ubaSync1 <= '0;
         ubaSync2 <= '0;
      end else begin
         ubaSync1 <= ubaIRQ;
         ubaSync2 <= ubaSync1;
      end
   end

   // Level requests, so masking is enough
   assign ubaPending = ubaSync2 & levelActive;

endmodule

// File: hdl/piSequencer.sv
//////////////////////////////
// PI sequencer
// Merges APR and Unibus requests, tracks levels
// in progress and offers the best one
//////////////////////////////

module piSequencer (
   input  logic                  clk,             // Clock
   input  logic                  rst,             // Synchronous reset
   input  ks10IntrPkg::aprCmdT   cmd,             // Command port
   input  ks10IntrPkg::piReqT    aprReq,          // APR request
   input  ks10IntrPkg::piMaskT   ubaPending,      // Unibus requests
   input  ks10IntrPkg::piMaskT   levelActive,     // Enabled levels
   output logic                  intValid,        // Offer valid
   output ks10IntrPkg::piLevelT  intLevel,        // Offered level
   input  logic                  intReady,        // Processor accepts
   output ks10IntrPkg::piLevelT  piCurrent        // Highest in progress
);

   logic                    dismiss;              // Decoded piDismiss
   logic                    xfer;                 // Offer taken this cycle
   ks10IntrPkg::piMaskT     aprMask;              // APR request as a mask
   ks10IntrPkg::piMaskT     pendMask;             // All pending levels
   ks10IntrPkg::piMaskT     eligMask;             // Above current level
   ks10IntrPkg::piMaskT     inProgress;           // Levels being serviced
   ks10IntrPkg::piMaskT     progNext;
   ks10IntrPkg::piLevelT    bestLevel;            // Highest eligible

   // Lowest set index wins, 0 if empty
   function automatic ks10IntrPkg::piLevelT highest(input ks10IntrPkg::piMaskT m);
      ks10IntrPkg::piLevelT lvl;
      lvl = '0;
      for (int n = 7; n >= 1; n--) begin
         if (m[n]) begin
            lvl = 3'(n);                          // Later hits are higher
         end
      end
      return lvl;
   endfunction

   //////////////////////////////
   // Pending and eligible
   //////////////////////////////

   assign dismiss = cmd.valid && (cmd.op == ks10IntrPkg::piDismiss);
   assign xfer    = intValid && intReady;

   always_comb begin
      aprMask = '0;
      for (int n = 1; n <= 7; n++) begin
         aprMask[n] = aprReq.valid && (aprReq.level == 3'(n));
      end
   end

   // APR only counts on an active level
   assign pendMask  = ubaPending | (aprMask & levelActive);
   assign piCurrent = highest(inProgress);

   always_comb begin
      eligMask = '0;
      for (int n = 1; n <= 7; n++) begin
         // Must beat the level in progress
         eligMask[n] = pendMask[n] && ((piCurrent == '0) || (3'(n) < piCurrent));
      end
   end

   assign bestLevel = highest(eligMask);

   //////////////////////////////
   // In-progress tracking
   //////////////////////////////

   always_comb begin
      progNext = inProgress;
      if (dismiss && (piCurrent != '0)) begin
         progNext[piCurrent] = 1'b0;              // End highest
      end
      if (xfer) begin
         progNext[intLevel] = 1'b1;               // Accepted level starts
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         inProgress <= '0;
      end else begin
         inProgress <= progNext;
      end
   end

   //////////////////////////////
   // Offer register
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         intValid <= 1'b0;
         intLevel <= '0;
      end else if (xfer) begin
         intValid <= 1'b0;                        // Gap after transfer
      end else if (!intValid && (bestLevel != '0)) begin
         intValid <= 1'b1;
         intLevel <= bestLevel;
      end
      // Held offer stays put under back-pressure
   end

endmodule

// File: hdl/ks10Intr.sv
//////////////////////////////
// KS10 interrupt system
// APR flags and PI levels side by side,
// combined by the PI sequencer
//////////////////////////////

module ks10Intr #(
   parameter int tickCycles = 40                  // Timer prescale
) (
   input  logic                  clk,             // Clock
   input  logic                  rst,             // Synchronous reset
   input  ks10IntrPkg::aprCmdT   cmd,             // Command port
   input  ks10IntrPkg::aprIrqT   aprIrq,          // APR pulses
   input  ks10IntrPkg::piMaskT   ubaIRQ,          // Unibus requests
   input  logic                  timerEN,         // Timer enable
   output logic                  intValid,        // Interrupt offer
   output ks10IntrPkg::piLevelT  intLevel,        // Offered level
   input  logic                  intReady,        // Processor accepts
   output ks10IntrPkg::piLevelT  piCurrent        // Level in progress
);

   ks10IntrPkg::piReqT      aprReq;               // APR to sequencer
   ks10IntrPkg::piMaskT     ubaPending;           // Masked Unibus requests
   ks10IntrPkg::piMaskT     levelActive;          // Enabled levels

   //////////////////////////////
   // APR flags and timer
   //////////////////////////////

   aprFlags #(
      .tickCycles(tickCycles)
   ) uAprFlags (
      .clk(clk),
      .rst(rst),
      .cmd(cmd),
      .aprIrq(aprIrq),
      .timerEN(timerEN),
      .aprReq(aprReq)
   );

   //////////////////////////////
   // PI levels
   //////////////////////////////

   piLevels uPiLevels (
      .clk(clk),
      .rst(rst),
      .cmd(cmd),
      .ubaIRQ(ubaIRQ),
      .ubaPending(ubaPending),
      .levelActive(levelActive)
   );

   // Sequencer merges both sources
   piSequencer uPiSequencer (
      .clk(clk),
      .rst(rst),
      .cmd(cmd),
      .aprReq(aprReq),
      .ubaPending(ubaPending),
      .levelActive(levelActive),
      .intValid(intValid),
      .intLevel(intLevel),
      .intReady(intReady),
      .piCurrent(piCurrent)
   );

endmodule

// File: test/tbClock.sv
//////////////////////////////
// Testbench clock
// Free-running clock, even duty cycle
//////////////////////////////

module tbClock #(
   parameter int period = 100                     // Clock period
) (
   output logic clk                               // Testbench clock
);

   initial begin
      clk = 1'b0;
   end

   always #(period / 2) clk = ~clk;               // Half period per phase

endmodule

// File: test/tbKs10Intr.sv
//////////////////////////////
// KS10 interrupt testbench
// Random stimulus against a reference model of
// the APR flags, PI levels and sequencer
//////////////////////////////

module tbKs10Intr;

   localparam int clkPeriod  = 100;
   localparam int tickCycles = 40;
   localparam int resetLen   = 8;
   localparam int settle     = 6;                 // Wait before a check
   localparam int iterCount  = 8;                 // Rounds per random test
   // Rough length of all tests in cycles
   localparam int testCycles = (resetLen + 2) + iterCount * (resetLen + settle + 8)
      + iterCount * (resetLen + 2 * settle + 20) + (resetLen + 60 + 5 * settle)
      + (2 * resetLen + 20 + 4 * tickCycles + settle);
   localparam int watchdogCycles = testCycles * 2 + 100;

   logic                  clk;
   logic                  rst;
   ks10IntrPkg::aprCmdT   cmd;
   ks10IntrPkg::aprIrqT   aprIrq;
   ks10IntrPkg::piMaskT   ubaIRQ;
   logic                  timerEN;
   logic                  intValid;
   ks10IntrPkg::piLevelT  intLevel;
   logic                  intReady;
   ks10IntrPkg::piLevelT  piCurrent;

   //////////////////////////////
   // Reference model state
   //////////////////////////////

   logic [3:0]  mFlags;                           // pwr nxm cons timer
   logic [3:0]  mEn;                              // Flag enables
   logic [2:0]  mAprLvl;
   logic        mPiOn;
   logic [7:1]  mLevelEn;
   logic [7:1]  mInProg;                          // Levels in progress
   logic [7:1]  mUba;                             // Driven Unibus lines
   logic        expValid;                         // Offer held by the model
   logic [2:0]  expLevel;

   logic [15:0] lfsr;
   int          checkCount;
   int          errorCount;
   int          testChecks;                       // Counts at test start
   int          testErrors;

   tbClock #(
      .period(clkPeriod)
   ) uClock (
      .clk(clk)
   );

   ks10Intr #(
      .tickCycles(tickCycles)
   ) dut0 (
      .clk(clk),
      .rst(rst),
      .cmd(cmd),
      .aprIrq(aprIrq),
      .ubaIRQ(ubaIRQ),
      .timerEN(timerEN),
      .intValid(intValid),
      .intLevel(intLevel),
      .intReady(intReady),
      .piCurrent(piCurrent)
   );

   //////////////////////////////
   // Random numbers and model
   //////////////////////////////

   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois, taps 16 14 13 11
   endfunction

   // One LFSR step per bit taken
   function automatic logic [15:0] randBits(input int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r[i] = lfsr[0];
         lfsr = lfsrNext(lfsr);
      end
      return r;
   endfunction

   // Level 1 is highest priority
   function automatic logic [2:0] firstSet(input logic [7:1] m);
      for (int n = 1; n <= 7; n++) begin
         if (m[n]) begin
            return 3'(n);
         end
      end
      return 3'd0;
   endfunction

   function automatic logic [2:0] modelBest();
      logic [7:1] active;
      logic [7:1] pend;
      logic [2:0] cur;
      active = mPiOn ? mLevelEn : 7'd0;
      pend   = mUba & active;
      if ((|(mFlags & mEn)) && (mAprLvl != 3'd0) && active[mAprLvl]) begin
         pend[mAprLvl] = 1'b1;                    // APR joins its level
      end
      cur = firstSet(mInProg);
      for (int n = 1; n <= 7; n++) begin
         if (pend[n] && ((cur == 3'd0) || (n < cur))) begin
            return 3'(n);
         end
      end
      return 3'd0;
   endfunction

   task automatic compareValue(input string name, input logic [7:0] expv,
                               input logic [7:0] actv);
      checkCount++;
      assert (actv === expv) else begin
         $display("MISMATCH time=%0t signal=%0s expected=%0h actual=%0h",
                  $time, name, expv, actv);
         errorCount++;
      end
   endtask

   //////////////////////////////
   // Drivers
   //////////////////////////////

   task automatic resetDut();
      @(posedge clk);
      rst      <= 1'b1;
      cmd      <= '0;
      aprIrq   <= '0;
      ubaIRQ   <= '0;
      timerEN  <= 1'b0;
      intReady <= 1'b0;
      repeat (resetLen) @(posedge clk);
      rst      <= 1'b0;
      mFlags   = '0;
      mEn      = '0;
      mAprLvl  = '0;
      mPiOn    = 1'b0;
      mLevelEn = '0;
      mInProg  = '0;
      mUba     = '0;
      expValid = 1'b0;
   endtask

   // Valid for one edge, model follows
   task automatic sendCmd(input ks10IntrPkg::aprOpT op, input logic [9:0] data);
      logic [2:0] cur;
      @(posedge clk);
      cmd <= '{valid: 1'b1, op: op, data: data};
      @(posedge clk);
      cmd <= '0;
      cur = firstSet(mInProg);
      case (op)
         ks10IntrPkg::aprClrFlags:   mFlags = mFlags & ~data[3:0];
         ks10IntrPkg::aprSetEnables: mEn = data[3:0];
         ks10IntrPkg::aprSetLevel:   mAprLvl = data[2:0];
         ks10IntrPkg::piSetOn: begin
            mPiOn    = data[7];
            mLevelEn = data[6:0];
         end
         ks10IntrPkg::piDismiss: begin
            if (cur != 3'd0) begin
               mInProg[cur] = 1'b0;
            end
         end
         default: ;
      endcase
   endtask

   // Sampled mid-cycle, away from the edge
   task automatic checkOffer();
      @(negedge clk);
      if (!expValid) begin
         expLevel = modelBest();
         expValid = (expLevel != 3'd0);
      end
      compareValue("intValid", 8'(expValid), 8'(intValid));
      if (expValid) begin
         compareValue("intLevel", 8'(expLevel), 8'(intLevel));
      end
      compareValue("piCurrent", 8'(firstSet(mInProg)), 8'(piCurrent));
   endtask

   task automatic acceptOffer();
      @(posedge clk);
      intReady <= 1'b1;
      @(posedge clk);
      intReady <= 1'b0;                           // Transfer at this edge
      mInProg[expLevel] = 1'b1;
      expValid = 1'b0;
   endtask

   task automatic testDone(input string name);
      $display("Test %0s done: %0d checks, %0d errors", name,
               checkCount - testChecks, errorCount - testErrors);
      testChecks = checkCount;
      testErrors = errorCount;
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic runUnibus();
      for (int i = 0; i < iterCount; i++) begin
         resetDut();
         @(posedge clk);
         mUba   = 7'(randBits(7));
         ubaIRQ <= mUba;
         sendCmd(ks10IntrPkg::piSetOn, {2'b00, 8'(randBits(8))});
         repeat (settle) @(posedge clk);
         checkOffer();
      end
   endtask

   task automatic runAprFlags();
      for (int i = 0; i < iterCount; i++) begin
         resetDut();
         sendCmd(ks10IntrPkg::piSetOn, {2'b00, 1'b1, 7'(randBits(7))});
         sendCmd(ks10IntrPkg::aprSetEnables, 10'(randBits(4)));
         sendCmd(ks10IntrPkg::aprSetLevel, 10'(randBits(3)));
         @(posedge clk);
         aprIrq <= 3'(randBits(3));               // One-cycle pulse
         @(posedge clk);
         mFlags = mFlags | {aprIrq, 1'b0};
         aprIrq <= '0;
         repeat (settle) @(posedge clk);
         checkOffer();
         sendCmd(ks10IntrPkg::aprClrFlags, 10'(randBits(4)));
         if (expValid) begin
            acceptOffer();                        // Free the held offer
            sendCmd(ks10IntrPkg::piDismiss, '0);
         end
         repeat (settle) @(posedge clk);
         checkOffer();
      end
   endtask

   task automatic runNesting();
      logic [2:0] lvl;
      logic [7:1] m;
      int         hold;
      resetDut();
      lvl = 3'(randBits(3));
      if (lvl == 3'd0) begin
         lvl = 3'd7;
      end
      m      = '0;
      m[lvl] = 1'b1;
      @(posedge clk);
      ubaIRQ <= m;
      mUba   = m;
      sendCmd(ks10IntrPkg::piSetOn, 10'h0FF);     // PI on, all levels
      repeat (settle) @(posedge clk);
      checkOffer();
      hold = randBits(4);
      @(posedge clk);
      mUba   = mUba | 7'(randBits(7));            // New requests under stall
      ubaIRQ <= mUba;
      repeat (hold + 3) checkOffer();
      acceptOffer();
      repeat (settle) @(posedge clk);
      checkOffer();
      if (expValid) begin
         acceptOffer();                           // Nested higher level
         repeat (settle) @(posedge clk);
         checkOffer();
      end
      repeat (2) begin
         sendCmd(ks10IntrPkg::piDismiss, '0);
         repeat (settle) @(posedge clk);
         checkOffer();
      end
   endtask

   task automatic runTimer();
      logic [2:0] lvl;
      logic       seen;
      lvl = 3'(randBits(3));
      if (lvl == 3'd0) begin
         lvl = 3'd1;
      end
      for (int pass = 0; pass < 2; pass++) begin
         resetDut();
         sendCmd(ks10IntrPkg::piSetOn, 10'h0FF);
         sendCmd(ks10IntrPkg::aprSetEnables, 10'h001);    // Timer flag only
         sendCmd(ks10IntrPkg::aprSetLevel, {7'd0, lvl});
         @(posedge clk);
         timerEN <= (pass == 0);
         if (pass == 0) begin
            seen = 1'b0;
            for (int i = 0; (i < tickCycles + settle) && !seen; i++) begin
               @(negedge clk);
               seen = intValid;
            end
            checkCount++;
            assert (seen) else begin
               $display("No timer interrupt offered within %0d cycles, time %0t",
                        tickCycles + settle, $time);
               errorCount++;
            end
            if (seen) begin
               compareValue("intLevel", 8'(lvl), 8'(intLevel));
            end
         end else begin
            repeat (3 * tickCycles) begin
               @(negedge clk);
               compareValue("intValid", 8'd0, 8'(intValid));   // Timer stopped
            end
         end
      end
   endtask

   //////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////

   initial begin
      rst        = 1'b1;
      cmd        = '0;
      aprIrq     = '0;
      ubaIRQ     = '0;
      timerEN    = 1'b0;
      intReady   = 1'b0;
      lfsr       = 16'd63;
      checkCount = 0;
      errorCount = 0;
      testChecks = 0;
      testErrors = 0;
      resetDut();
      checkOffer();
      testDone("reset");
      runUnibus();
      testDone("unibus priority");
      runAprFlags();
      testDone("apr flags");
      runNesting();
      testDone("back-pressure and nesting");
      runTimer();
      testDone("timer");
      $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   initial begin
      #(watchdogCycles * clkPeriod);
      $display("Timeout: tests did not finish within %0d cycles", watchdogCycles);
      $display("Verification failed");
      $finish;
   end

endmodule

// File: sources.f
hdl/ks10IntrPkg.sv
hdl/aprFlags.sv
hdl/piLevels.sv
hdl/piSequencer.sv
hdl/ks10Intr.sv
test/tbClock.sv
test/tbKs10Intr.sv
